// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f tb.f --top-module fc_tb -o fc_tb_sim

out=$(./obj_dir/fc_tb_sim)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: sim/fc_tb_model.svh
`ifndef FC_TB_MODEL_SVH
`define FC_TB_MODEL_SVH

`include "fc_macros.svh"

// Reference model
// Vectors are 16-bit words, element 0 in the low nibble

// Kept bytes from byte 0 up, low nibble first
// Nothing lands past the vector end
function automatic void model_merge_beat(inout logic [15:0] vec, inout int fill,
                                         input logic [31:0] data, input logic [3:0] keep);
    for (int b = 0; b < 4; b++) begin
        for (int n = 0; n < 2; n++) begin
            if (keep[b] && fill < `FC_IN_WIDTH) begin
                vec[fill*4 +: 4] = data[b*8 + n*4 +: 4];
                fill = fill + 1;
            end
        end
    end
endfunction

// Output j sums x[i] * w(j, i), then clamps at 15
function automatic logic [15:0] model_layer(input logic [15:0] x, input logic [63:0] w);
    logic [15:0] y;
    int          sum;
    y = '0;
    for (int j = 0; j < 4; j++) begin
        sum = 0;
        for (int i = 0; i < 4; i++) begin
            sum = sum + int'(x[i*4 +: 4]) * int'(w[(j*4 + i)*4 +: 4]);
        end
        y[j*4 +: 4] = (sum > 15) ? 4'd15 : sum[3:0];
    end
    return y;
endfunction

// Three layers back to back
function automatic logic [15:0] model_network(input logic [15:0] x);
    return model_layer(model_layer(model_layer(x, `FC_LAY1_WEIGHTS), `FC_LAY2_WEIGHTS),
                       `FC_LAY3_WEIGHTS);
endfunction

`endif

// File: sim/fc_tb.sv
`timescale 1ns/1ps

`include "fc_macros.svh"

module fc_tb;

    import axis_pkg::*;
    import fc_types_pkg::*;

    // Cycles any single wait may take
    localparam int TIMEOUT = 200;

    // ------------------------------
    // DUT signals and test state
    // ------------------------------

    logic                         axi_clk;
    logic                         axi_reset_n;
    logic                         s_axis_valid;
    axis_data_t                   s_axis_data;
    axis_keep_t                   s_axis_keep;
    logic                         s_axis_last;
    logic                         s_axis_ready;
    logic                         fc_out_valid;
    fc_elem_t [`FC_OUT_WIDTH-1:0] fc_out;
    logic                         fc_out_ready;

    int           seed;
    int           cycle_cnt = 0;
    int           accept_cycle;
    int           recv_cycle;
    int           test_errs;
    int           pass_cnt = 0;
    int           fail_cnt = 0;
    string        cur_test;
    logic [15:0]  exp_q[$];
    // Packet to send, up to four beats
    axis_data_t   pkt_data[4];
    axis_keep_t   pkt_keep[4];
    int           pkt_len;
    // Ready pattern for the random stream
    logic [511:0] ready_pat;
    int           ready_idx;

    `include "fc_tb_model.svh"

    fc_network_top fc_network_top_i (
        .axi_clk      (axi_clk),
        .axi_reset_n  (axi_reset_n),
        .s_axis_valid (s_axis_valid),
        .s_axis_data  (s_axis_data),
        .s_axis_keep  (s_axis_keep),
        .s_axis_last  (s_axis_last),
        .s_axis_ready (s_axis_ready),
        .fc_out_valid (fc_out_valid),
        .fc_out       (fc_out),
        .fc_out_ready (fc_out_ready)
    );

    initial begin
        axi_clk = 1'b0;
        forever #5 axi_clk = ~axi_clk;
    end

    // Edge count for latency
    always @(posedge axi_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------
    // Bookkeeping
    // ------------------------------

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("%s: done, %0d errors", cur_test, test_errs);
    endtask

    task automatic report_mismatch(input string what, input logic [15:0] exp,
                                   input logic [15:0] act);
        $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
        test_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", cur_test, msg);
        test_errs++;
    endtask

    // ------------------------------
    // Stream driver and result check
    // ------------------------------

    // Beat stays valid until ready is seen ahead of an edge
    task automatic send_beat(input axis_data_t data, input axis_keep_t keep,
                             input logic last, output bit ok);
        int waited;
        waited       = 0;
        s_axis_valid = 1'b1;
        s_axis_data  = data;
        s_axis_keep  = keep;
        s_axis_last  = last;
        // Ready is settled by the falling edge
        @(negedge axi_clk);
        while (!s_axis_ready && waited < TIMEOUT) begin
            waited++;
            @(negedge axi_clk);
        end
        ok           = s_axis_ready;
        // Beat goes across on the coming rising edge
        accept_cycle = cycle_cnt + 1;
        if (!ok) begin
            report_problem("timed out waiting for s_axis_ready");
        end
        @(posedge axi_clk);
        #1;
        s_axis_valid = 1'b0;
        s_axis_last  = 1'b0;
    endtask

    // Expected result queued once last is taken
    task automatic send_packet();
        logic [15:0] vec;
        int          fill;
        bit          ok;
        vec  = '0;
        fill = 0;
        for (int k = 0; k < pkt_len; k++) begin
            model_merge_beat(vec, fill, pkt_data[k], pkt_keep[k]);
            send_beat(pkt_data[k], pkt_keep[k], k == pkt_len - 1, ok);
            if (!ok) begin
                return;
            end
        end
        exp_q.push_back(model_network(vec));
    endtask

    // Ready held high, or taken bit by bit from ready_pat
    task automatic receive_result(input bit rand_ready);
        int          waited;
        bit          got;
        logic [15:0] exp;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < TIMEOUT) begin
            if (rand_ready) begin
                fc_out_ready = ready_pat[ready_idx];
                ready_idx    = (ready_idx + 1) % 512;
            end else begin
                fc_out_ready = 1'b1;
            end
            // Handshake for the coming edge, sampled mid-cycle
            @(negedge axi_clk);
            if (fc_out_valid && fc_out_ready) begin
                got        = 1'b1;
                recv_cycle = cycle_cnt;
                if (exp_q.size() == 0) begin
                    report_problem("result arrived with no packet outstanding");
                end else begin
                    exp = exp_q.pop_front();
                    if (fc_out !== exp) begin
                        report_mismatch("fc_out", exp, fc_out);
                    end
                end
            end
            waited++;
            @(posedge axi_clk);
            #1;
        end
        if (!got) begin
            report_problem("timed out waiting for fc_out_valid");
        end
    endtask

    task automatic build_random_packet();
        pkt_len = 1 + int'($unsigned($random(seed)) % 4);
        for (int k = 0; k < 4; k++) begin
            pkt_data[k] = $random(seed);
            pkt_keep[k] = axis_keep_t'($random(seed));
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    // Packet of one or two beats into an empty pipeline
    task automatic test_directed(input string name, input int len,
                                 input axis_data_t d0, input axis_keep_t k0,
                                 input axis_data_t d1, input axis_keep_t k1);
        start_test(name);
        pkt_len     = len;
        pkt_data[0] = d0;
        pkt_keep[0] = k0;
        pkt_data[1] = d1;
        pkt_keep[1] = k1;
        send_packet();
        receive_result(1'b0);
        // Edges from the accepting edge to the one that raises valid
        if (recv_cycle - accept_cycle != 4) begin
            report_mismatch("latency", 16'd4, 16'(recv_cycle - accept_cycle));
        end
        end_test();
    endtask

    task automatic test_back_pressure();
        logic [15:0] held;
        int          waited;
        start_test("back_pressure");
        fc_out_ready = 1'b0;
        // Three single-beat packets, taken before the stall reaches the input
        for (int p = 0; p < 3; p++) begin
            pkt_len     = 1;
            pkt_data[0] = $random(seed);
            pkt_keep[0] = 4'hf;
            send_packet();
        end
        waited = 0;
        @(negedge axi_clk);
        while (!fc_out_valid && waited < TIMEOUT) begin
            waited++;
            @(negedge axi_clk);
        end
        if (!fc_out_valid) begin
            report_problem("timed out waiting for the first stalled result");
        end
        held = fc_out;
        for (int c = 0; c < 8; c++) begin
            @(negedge axi_clk);
            if (s_axis_ready) begin
                report_problem("s_axis_ready high while the output is stalled");
            end
            if (!fc_out_valid) begin
                report_problem("fc_out_valid dropped while the output is stalled");
            end
            if (fc_out !== held) begin
                report_mismatch("held fc_out", held, fc_out);
            end
        end
        @(posedge axi_clk);
        #1;
        for (int p = 0; p < 3; p++) begin
            receive_result(1'b0);
        end
        end_test();
    endtask

    task automatic test_random_stream();
        start_test("random_stream");
        for (int k = 0; k < 16; k++) begin
            ready_pat[k*32 +: 32] = $random(seed);
        end
        ready_idx = 0;
        fork
            begin
                for (int p = 0; p < 20; p++) begin
                    build_random_packet();
                    send_packet();
                end
            end
            begin
                for (int p = 0; p < 20; p++) begin
                    receive_result(1'b1);
                end
            end
        join
        fc_out_ready = 1'b1;
        if (exp_q.size() != 0) begin
            report_problem("expected results were never received");
        end
        end_test();
    endtask

    initial begin
        seed         = 7068;
        axi_reset_n  = 1'b0;
        s_axis_valid = 1'b0;
        s_axis_data  = '0;
        s_axis_keep  = '0;
        s_axis_last  = 1'b0;
        fc_out_ready = 1'b0;
        ready_pat    = '0;
        ready_idx    = 0;
        pkt_len      = 0;
        repeat (3) @(posedge axi_clk);
        #1;
        axi_reset_n = 1'b1;
        test_directed("single_vector", 1, 32'h5a3c_2d17, 4'hf, '0, '0);
        // Unkept bytes carry junk that must not show up
        test_directed("partial_keep", 2, 32'hffff_ff35, 4'b0001, 32'heeee_ee12, 4'b0001);
        test_directed("short_packet", 1, 32'h9999_9942, 4'b0001, '0, '0);
        test_directed("saturation", 1, 32'hffff_ffff, 4'hf, '0, '0);
        test_back_pressure();
        test_random_stream();
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: source/axis_pkg.sv
// AXI4-Stream beat fields
package axis_pkg;

    // Beat width in bits
    localparam int AXIS_DATA_WIDTH = 32;

    // One keep bit per byte
    localparam int AXIS_KEEP_WIDTH = AXIS_DATA_WIDTH / 8;

    // Elements carried by each kept byte
    localparam int NIBBLES_PER_BYTE = 2;

    // Beat data and byte enables
    typedef logic [AXIS_DATA_WIDTH-1:0] axis_data_t;
    typedef logic [AXIS_KEEP_WIDTH-1:0] axis_keep_t;

endpackage

// File: source/axis_unpacker.sv
`timescale 1ns/1ps

`include "fc_macros.svh"

// Stream to vector conversion, first pipeline stage
module axis_unpacker (
    input  logic                                        axi_clk,
    input  logic                                        axi_reset_n,
    input  logic                                        advance,
    input  logic                                        s_axis_valid,
    input  logic                                        s_axis_last,
    input  axis_pkg::axis_data_t                        s_axis_data,
    input  axis_pkg::axis_keep_t                        s_axis_keep,
    output logic                                        s_axis_ready,
    output logic                                        vec_valid,
    output fc_types_pkg::fc_elem_t [`FC_IN_WIDTH-1:0]   vec_data
);

    import axis_pkg::*;
    import fc_types_pkg::*;

    // Count runs 0 to FC_IN_WIDTH inclusive
    localparam int CNT_W = $clog2(`FC_IN_WIDTH + 1);

    // Bits per byte lane
    localparam int BYTE_BITS = AXIS_DATA_WIDTH / AXIS_KEEP_WIDTH;

    // ------------------------------
    // Partial packet state
    // ------------------------------

    fc_elem_t [`FC_IN_WIDTH-1:0] part_vec;
    logic [CNT_W-1:0]            fill_cnt;

    // Partial vector with this beat merged in
    fc_elem_t [`FC_IN_WIDTH-1:0] merged_vec;
    logic [CNT_W-1:0]            merged_cnt;

    logic beat_accept;

    // Beats move only when the whole pipeline moves
    assign s_axis_ready = advance;
    assign beat_accept  = s_axis_valid && advance;

    // ------------------------------
    // Nibble placement
    // ------------------------------

    always_comb begin
        int fill;
        merged_vec = part_vec;
        fill       = int'(fill_cnt);
        // Byte 0 first, low nibble first
        for (int b = 0; b < AXIS_KEEP_WIDTH; b++) begin
            if (s_axis_keep[b]) begin
                for (int n = 0; n < NIBBLES_PER_BYTE; n++) begin
                    // Nibbles past the vector end are dropped
                    if (fill < `FC_IN_WIDTH) begin
                        merged_vec[fill] =
                            s_axis_data[b*BYTE_BITS + n*`FC_DATA_WIDTH +: `FC_DATA_WIDTH];
                        fill = fill + 1;
                    end
                end
            end
        end
        merged_cnt = CNT_W'(fill);
    end

    // ------------------------------
    // State and output registers
    // ------------------------------

    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            fill_cnt  <= '0;
            part_vec  <= '0;
            vec_valid <= 1'b0;
        end else if (advance) begin
            // Published vector lasts one advancing cycle
            vec_valid <= 1'b0;
            if (beat_accept) begin
                if (s_axis_last) begin
                    vec_valid <= 1'b1;
                    // Next packet starts empty so unfilled slots read zero
                    fill_cnt  <= '0;
                    part_vec  <= '0;
                end else begin
                    fill_cnt  <= merged_cnt;
                    part_vec  <= merged_vec;
                end
            end
        end
    end

    // Payload only
    always_ff @(posedge axi_clk) begin
        if (beat_accept && s_axis_last) begin
            vec_data <= merged_vec;
        end
    end

endmodule

// File: source/fc_layer.sv
`timescale 1ns/1ps

`include "fc_macros.svh"

// One fully connected layer, one registered stage
module fc_layer #(
    parameter int in_width  = 4,
    parameter int out_width = 4
) (
    input  logic                                        axi_clk,
    input  logic                                        axi_reset_n,
    input  logic                                        advance,
    input  logic [in_width*out_width*`FC_DATA_WIDTH-1:0] weights,
    input  logic                                        in_valid,
    input  fc_types_pkg::fc_elem_t [in_width-1:0]       in_data,
    output logic                                        out_valid,
    output fc_types_pkg::fc_elem_t [out_width-1:0]      out_data
);

    import fc_types_pkg::*;

    // ------------------------------
    // Weight unpacking
    // ------------------------------

    // Flat weight index j*in_width + i
    fc_elem_t [in_width*out_width-1:0] w_elem;

    assign w_elem = weights;

    // ------------------------------
    // Dot products
    // ------------------------------

    // Saturated layer result ahead of the register
    fc_elem_t [out_width-1:0] dot_sat;

    always_comb begin
        fc_acc_t acc;
        for (int j = 0; j < out_width; j++) begin
            acc = '0;
            // Sum of input times weight(j, i)
            for (int i = 0; i < in_width; i++) begin
                acc = acc + fc_acc_t'(in_data[i]) * fc_acc_t'(w_elem[j*in_width + i]);
            end
            // Clamp at the element maximum
            if (acc > fc_acc_t'(FC_ELEM_MAX)) begin
                dot_sat[j] = FC_ELEM_MAX;
            end else begin
                dot_sat[j] = acc[`FC_DATA_WIDTH-1:0];
            end
        end
    end

    // ------------------------------
    // Stage register
    // ------------------------------

    // Valid tracks the data one advancing cycle later
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    // Hold while the pipeline is stalled
    always_ff @(posedge axi_clk) begin
        if (advance && in_valid) begin
            out_data <= dot_sat;
        end
    end

endmodule

// File: source/fc_macros.svh
`ifndef FC_MACROS_SVH
`define FC_MACROS_SVH

// ------------------------------
// Element format
// ------------------------------

// Every element, weight and activation is 4-bit unsigned
`define FC_DATA_WIDTH 4

// ------------------------------
// Vector sizes
// ------------------------------

// Input vector built by the unpacker
`define FC_IN_WIDTH 4

// Hidden layers
`define FC_HID1_WIDTH 4
`define FC_HID2_WIDTH 4

// Result vector held by the output stage
`define FC_OUT_WIDTH 4

// ------------------------------
// Layer weights
// ------------------------------

// 16 nibbles per layer
// Nibble index = out_j * in_width + in_i, nibble 0 at the LSB
// Small weights keep some outputs below the saturation limit

// Layer 1, input to hidden 1
`define FC_LAY1_WEIGHTS 64'h1002_0120_0011_2001

// Layer 2, hidden 1 to hidden 2
`define FC_LAY2_WEIGHTS 64'h0100_1001_0010_0101

// Layer 3, hidden 2 to output
`define FC_LAY3_WEIGHTS 64'h1000_0210_0001_0101

`endif

// File: source/fc_network_top.sv
`timescale 1ns/1ps

`include "fc_macros.svh"

// Stream-fed three layer FC network
module fc_network_top (
    input  logic                                        axi_clk,
    input  logic                                        axi_reset_n,
    // ------------------------------
    // Input stream
    // ------------------------------
    input  logic                                        s_axis_valid,
    input  axis_pkg::axis_data_t                        s_axis_data,
    input  axis_pkg::axis_keep_t                        s_axis_keep,
    input  logic                                        s_axis_last,
    output logic                                        s_axis_ready,
    // ------------------------------
    // Result port
    // ------------------------------
    output logic                                        fc_out_valid,
    output fc_types_pkg::fc_elem_t [`FC_OUT_WIDTH-1:0]  fc_out,
    input  logic                                        fc_out_ready
);

    import fc_types_pkg::*;

    // Shared stage enable from the output slot
    logic advance;

    // Stage to stage vectors
    logic                          in_vec_valid;
    fc_elem_t [`FC_IN_WIDTH-1:0]   in_vec;
    logic                          hid1_valid;
    fc_elem_t [`FC_HID1_WIDTH-1:0] hid1_vec;
    logic                          hid2_valid;
    fc_elem_t [`FC_HID2_WIDTH-1:0] hid2_vec;
    logic                          res_valid;
    fc_elem_t [`FC_OUT_WIDTH-1:0]  res_vec;

    // Stage 1, stream to vector
    axis_unpacker axis_unpacker_i (
        .axi_clk      (axi_clk),
        .axi_reset_n  (axi_reset_n),
        .advance      (advance),
        .s_axis_valid (s_axis_valid),
        .s_axis_last  (s_axis_last),
        .s_axis_data  (s_axis_data),
        .s_axis_keep  (s_axis_keep),
        .s_axis_ready (s_axis_ready),
        .vec_valid    (in_vec_valid),
        .vec_data     (in_vec)
    );

    // ------------------------------
    // Layers
    // ------------------------------

    fc_layer #(.in_width(`FC_IN_WIDTH), .out_width(`FC_HID1_WIDTH)) fc_lay_1 (
        .axi_clk (axi_clk), .axi_reset_n (axi_reset_n), .advance (advance),
        .weights (`FC_LAY1_WEIGHTS),
        .in_valid (in_vec_valid), .in_data (in_vec),
        .out_valid (hid1_valid), .out_data (hid1_vec)
    );

    fc_layer #(.in_width(`FC_HID1_WIDTH), .out_width(`FC_HID2_WIDTH)) fc_lay_2 (
        .axi_clk (axi_clk), .axi_reset_n (axi_reset_n), .advance (advance),
        .weights (`FC_LAY2_WEIGHTS),
        .in_valid (hid1_valid), .in_data (hid1_vec),
        .out_valid (hid2_valid), .out_data (hid2_vec)
    );

    fc_layer #(.in_width(`FC_HID2_WIDTH), .out_width(`FC_OUT_WIDTH)) fc_lay_3 (
        .axi_clk (axi_clk), .axi_reset_n (axi_reset_n), .advance (advance),
        .weights (`FC_LAY3_WEIGHTS),
        .in_valid (hid2_valid), .in_data (hid2_vec),
        .out_valid (res_valid), .out_data (res_vec)
    );

    // Last stage drives the enable for everything upstream
    fc_output_stage fc_output_stage_i (
        .axi_clk      (axi_clk),
        .axi_reset_n  (axi_reset_n),
        .in_valid     (res_valid),
        .in_data      (res_vec),
        .advance      (advance),
        .fc_out_ready (fc_out_ready),
        .fc_out_valid (fc_out_valid),
        .fc_out       (fc_out)
    );

endmodule

// File: source/fc_output_stage.sv
`timescale 1ns/1ps

`include "fc_macros.svh"

// Result holding slot and output handshake
module fc_output_stage (
    input  logic                                        axi_clk,
    input  logic                                        axi_reset_n,
    input  logic                                        in_valid,
    input  fc_types_pkg::fc_elem_t [`FC_OUT_WIDTH-1:0]  in_data,
    output logic                                        advance,
    input  logic                                        fc_out_ready,
    output logic                                        fc_out_valid,
    output fc_types_pkg::fc_elem_t [`FC_OUT_WIDTH-1:0]  fc_out
);

    // ------------------------------
    // Pipeline enable
    // ------------------------------

    // Slot empty or drained this cycle
    assign advance = !fc_out_valid || fc_out_ready;

    // ------------------------------
    // Holding register
    // ------------------------------

    // Occupancy follows layer 3 valid on advancing cycles
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            fc_out_valid <= 1'b0;
        end else if (advance) begin
            fc_out_valid <= in_valid;
        end
    end

    // Result stays put under back-pressure
    always_ff @(posedge axi_clk) begin
        if (advance && in_valid) begin
            fc_out <= in_data;
        end
    end

endmodule

// File: source/fc_types_pkg.sv
`include "fc_macros.svh"

// Data types of the network datapath
package fc_types_pkg;

    // ------------------------------
    // Elements
    // ------------------------------

    // One vector element, unsigned
    typedef logic [`FC_DATA_WIDTH-1:0] fc_elem_t;

    // Saturation limit of every layer output
    localparam fc_elem_t FC_ELEM_MAX = fc_elem_t'(15);

    // ------------------------------
    // Accumulation
    // ------------------------------

    // Dot product sum before saturation
    // Four 8-bit products fit in 12 bits
    typedef logic [3*`FC_DATA_WIDTH-1:0] fc_acc_t;

endpackage

// File: tb.f
+incdir+source
+incdir+sim
source/fc_types_pkg.sv
source/axis_pkg.sv
source/axis_unpacker.sv
source/fc_layer.sv
source/fc_output_stage.sv
source/fc_network_top.sv
sim/fc_tb.sv
